// File: hdl/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

////////////////////
// datapath widths
////////////////////

// operand and result word
`define ALU_WIDTH 16

// response sequence tag
`define ALU_TAG_WIDTH 8

////////////////////
// skid chain depths
////////////////////

`define CMD_PIPE_DEPTH 2
`define RSP_PIPE_DEPTH 2

`endif

// File: hdl/alu_rsp_pkg.sv
`include "alu_params.svh"

package alu_rsp_pkg;

  // one operand or result word
  typedef logic [`ALU_WIDTH-1:0] alu_word_t;

  // status bits returned with every response
  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
    logic overflow;
    logic illegal;
  } alu_flags_t;

  // output chain payload
  typedef struct packed {
    alu_word_t                 result;
    alu_flags_t                flags;
    logic [`ALU_TAG_WIDTH-1:0] tag;
  } alu_rsp_t;

endpackage

// File: hdl/alu_op_pkg.sv
package alu_op_pkg;
  import alu_rsp_pkg::*;

  // command opcodes, remaining codes are illegal
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_AND = 4'h2,
    OP_OR  = 4'h3,
    OP_XOR = 4'h4,
    OP_SHL = 4'h5,
    OP_SHR = 4'h6
  } alu_opcode_t;

  // input chain payload
  typedef struct packed {
    alu_opcode_t op;
    alu_word_t   a;
    alu_word_t   b;
  } alu_cmd_t;

  typedef enum logic [1:0] {
    UNIT_ARITH = 2'd0,
    UNIT_LOGIC = 2'd1,
    UNIT_SHIFT = 2'd2
  } alu_unit_t;

  // zero code gives a zero result
  typedef enum logic [1:0] {
    LOGIC_ZERO = 2'd0,
    LOGIC_AND  = 2'd1,
    LOGIC_OR   = 2'd2,
    LOGIC_XOR  = 2'd3
  } alu_logic_fn_t;

  typedef struct packed {
    alu_unit_t     unit;
    logic          invert_b;
    logic          carry_in;
    alu_logic_fn_t logic_fn;
    logic          shift_left;
    logic          illegal;
  } alu_ctrl_t;

endpackage

// File: hdl/alu_stage_if.sv
// one operation between the middle stages
interface alu_stage_if
  import alu_op_pkg::*, alu_rsp_pkg::*;
();

  logic      valid;
  logic      ready;
  alu_ctrl_t ctrl;

  // operands, filled by decode
  alu_word_t a;
  alu_word_t b;

  // outcome, filled by execute
  alu_word_t result;
  logic      carry;
  logic      overflow;

  modport producer (
    output valid, ctrl, a, b, result, carry, overflow,
    input  ready
  );

  modport consumer (
    input  valid, ctrl, a, b, result, carry, overflow,
    output ready
  );

endinterface

// File: hdl/skid_pipeline.sv
// output register plus one skid entry
module skid_stage #(
  parameter type T          = logic [7:0],
  parameter bit  PASS_STALL = 1'b0
) (
  input  logic clk,
  input  logic rstn,
  input  logic in_valid,
  input  T     in_data,
  output logic in_ready,
  output logic out_valid,
  output T     out_data,
  input  logic out_ready
);

  logic out_valid_r;
  T     out_data_r;
  logic out_free;

  assign out_free  = !out_valid_r || out_ready;
  assign out_valid = out_valid_r;
  assign out_data  = out_data_r;

  if (PASS_STALL) begin : g_pass
    // no skid, stall goes straight upstream
    assign in_ready = out_free;

    always_ff @(posedge clk) begin
      if (rstn) begin
        out_valid_r <= 1'b0;
      end else if (out_free) begin
        out_valid_r <= in_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (in_valid && out_free) begin
        out_data_r <= in_data;
      end
    end
  end else begin : g_skid
    T     skid_data;
    logic skid_valid;
    logic ready_r;
    logic take;

    // ready is registered, high only while the skid is empty
    assign in_ready = ready_r;
    assign take     = in_valid && ready_r;

    always_ff @(posedge clk) begin
      if (rstn) begin
        out_valid_r <= 1'b0;
        skid_valid  <= 1'b0;
        ready_r     <= 1'b0;
      end else if (out_free) begin
        // skid drains first, ready was low so nothing new arrives
        out_valid_r <= skid_valid || take;
        skid_valid  <= 1'b0;
        ready_r     <= 1'b1;
      end else if (take) begin
        // stalled output, catch the item in flight
        skid_valid <= 1'b1;
        ready_r    <= 1'b0;
      end
    end

    always_ff @(posedge clk) begin
      if (out_free) begin
        out_data_r <= skid_valid ? skid_data : in_data;
      end
      if (!out_free && take) begin
        skid_data <= in_data;
      end
    end
  end

endmodule

// chain of DEPTH skid stages, DEPTH of at least one
module skid_pipeline #(
  parameter type T               = logic [7:0],
  parameter int  DEPTH           = 2,
  parameter bit  PASS_LAST_STALL = 1'b0
) (
  input  logic clk,
  input  logic rstn,
  input  logic in_valid,
  input  T     in_data,
  output logic in_ready,
  output logic out_valid,
  output T     out_data,
  input  logic out_ready
);

  logic [DEPTH:0] valid_pipe;
  logic [DEPTH:0] ready_pipe;
  T               data_pipe [0:DEPTH];

  assign valid_pipe[0]     = in_valid;
  assign data_pipe[0]      = in_data;
  assign in_ready          = ready_pipe[0];
  assign out_valid         = valid_pipe[DEPTH];
  assign out_data          = data_pipe[DEPTH];
  assign ready_pipe[DEPTH] = out_ready;

  for (genvar i = 0; i < DEPTH; i++) begin : g_stage
    // only the last stage may pass its stall through
    localparam bit STAGE_PASS = (i == DEPTH - 1) ? PASS_LAST_STALL : 1'b0;

    skid_stage #(
      .T         (T),
      .PASS_STALL(STAGE_PASS)
    ) u_stage (
      .clk      (clk),
      .rstn     (rstn),
      .in_valid (valid_pipe[i]),
      .in_data  (data_pipe[i]),
      .in_ready (ready_pipe[i]),
      .out_valid(valid_pipe[i+1]),
      .out_data (data_pipe[i+1]),
      .out_ready(ready_pipe[i+1])
    );
  end

endmodule

// File: hdl/alu_decode.sv
module alu_decode
  import alu_op_pkg::*, alu_rsp_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  input  logic          in_valid,
  input  alu_cmd_t      in_cmd,
  output logic          in_ready,
  alu_stage_if.producer dec
);

  alu_ctrl_t ctrl_d;

  // accept when the output register is empty or being taken
  assign in_ready = !dec.valid || dec.ready;

  // nothing computed at this point
  assign dec.result   = '0;
  assign dec.carry    = 1'b0;
  assign dec.overflow = 1'b0;

  ////////////////////
  // opcode decode
  ////////////////////
  always_comb begin
    ctrl_d = '0;
    ctrl_d.unit = UNIT_LOGIC;
    ctrl_d.logic_fn = LOGIC_ZERO;
    case (in_cmd.op)
      OP_ADD: ctrl_d.unit = UNIT_ARITH;
      OP_SUB: begin
        // a + ~b + 1
        ctrl_d.unit     = UNIT_ARITH;
        ctrl_d.invert_b = 1'b1;
        ctrl_d.carry_in = 1'b1;
      end
      OP_AND: ctrl_d.logic_fn = LOGIC_AND;
      OP_OR:  ctrl_d.logic_fn = LOGIC_OR;
      OP_XOR: ctrl_d.logic_fn = LOGIC_XOR;
      OP_SHL: begin
        ctrl_d.unit       = UNIT_SHIFT;
        ctrl_d.shift_left = 1'b1;
      end
      OP_SHR: ctrl_d.unit = UNIT_SHIFT;
      default: ctrl_d.illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      dec.valid <= 1'b0;
    end else if (in_ready) begin
      dec.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      dec.ctrl <= ctrl_d;
      dec.a    <= in_cmd.a;
      dec.b    <= in_cmd.b;
    end
  end

endmodule

// File: hdl/alu_execute.sv
`include "alu_params.svh"

module alu_execute
  import alu_op_pkg::*, alu_rsp_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  alu_stage_if.consumer dec,
  alu_stage_if.producer exe
);

  alu_word_t         b_eff;
  logic [`ALU_WIDTH:0] sum;
  logic              overflow_d;
  alu_word_t         logic_res;
  alu_word_t         shift_res;
  alu_word_t         result_d;

  assign dec.ready = !exe.valid || exe.ready;

  // operands are consumed here
  assign exe.a = '0;
  assign exe.b = '0;

  ////////////////////
  // adder
  ////////////////////
  assign b_eff = dec.ctrl.invert_b ? ~dec.b : dec.b;
  assign sum   = {1'b0, dec.a} + {1'b0, b_eff} + {{`ALU_WIDTH{1'b0}}, dec.ctrl.carry_in};

  // same sign in, other sign out
  assign overflow_d = (dec.a[`ALU_WIDTH-1] == b_eff[`ALU_WIDTH-1]) &&
                      (sum[`ALU_WIDTH-1] != dec.a[`ALU_WIDTH-1]);

  always_comb begin
    case (dec.ctrl.logic_fn)
      LOGIC_AND: logic_res = dec.a & dec.b;
      LOGIC_OR:  logic_res = dec.a | dec.b;
      LOGIC_XOR: logic_res = dec.a ^ dec.b;
      default:   logic_res = '0;
    endcase
  end

  // shift amount from the low four bits of b, zero fill
  assign shift_res = dec.ctrl.shift_left ? (dec.a << dec.b[3:0]) : (dec.a >> dec.b[3:0]);

  always_comb begin
    if (dec.ctrl.illegal) begin
      result_d = '0;
    end else begin
      case (dec.ctrl.unit)
        UNIT_ARITH: result_d = sum[`ALU_WIDTH-1:0];
        UNIT_LOGIC: result_d = logic_res;
        UNIT_SHIFT: result_d = shift_res;
        default:    result_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      exe.valid <= 1'b0;
    end else if (dec.ready) begin
      exe.valid <= dec.valid;
    end
  end

  // ctrl rides along so result can mask the flags
  always_ff @(posedge clk) begin
    if (dec.valid && dec.ready) begin
      exe.ctrl     <= dec.ctrl;
      exe.result   <= result_d;
      exe.carry    <= sum[`ALU_WIDTH];
      exe.overflow <= overflow_d;
    end
  end

endmodule

// File: hdl/alu_result.sv
`include "alu_params.svh"

module alu_result
  import alu_op_pkg::*, alu_rsp_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  alu_stage_if.consumer exe,
  output logic          out_valid,
  output alu_rsp_t      out_rsp,
  input  logic          out_ready
);

  logic [`ALU_TAG_WIDTH-1:0] tag_cnt;
  alu_flags_t                flags_d;
  logic                      is_arith;
  logic                      take;

  assign exe.ready = !out_valid || out_ready;
  assign take      = exe.valid && exe.ready;
  assign is_arith  = (exe.ctrl.unit == UNIT_ARITH);

  ////////////////////
  // flags
  ////////////////////
  assign flags_d.zero     = (exe.result == '0);
  assign flags_d.negative = exe.result[`ALU_WIDTH-1];
  assign flags_d.carry    = is_arith && exe.carry;
  assign flags_d.overflow = is_arith && exe.overflow;
  assign flags_d.illegal  = exe.ctrl.illegal;

  always_ff @(posedge clk) begin
    if (rstn) begin
      out_valid <= 1'b0;
      tag_cnt   <= '0;
    end else begin
      if (exe.ready) begin
        out_valid <= exe.valid;
      end
      // one tag per response registered
      if (take) begin
        tag_cnt <= tag_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_rsp.result <= exe.result;
      out_rsp.flags  <= flags_d;
      out_rsp.tag    <= tag_cnt;
    end
  end

endmodule

// File: hdl/stream_alu_top.sv
`include "alu_params.svh"

module stream_alu_top
  import alu_op_pkg::*, alu_rsp_pkg::*;
(
  input  logic                      clk,
  input  logic                      rstn,
  // command port
  input  logic                      cmd_valid,
  input  alu_opcode_t               cmd_op,
  input  alu_word_t                 cmd_a,
  input  alu_word_t                 cmd_b,
  output logic                      cmd_ready,
  // response port
  output logic                      rsp_valid,
  output alu_word_t                 rsp_result,
  output alu_flags_t                rsp_flags,
  output logic [`ALU_TAG_WIDTH-1:0] rsp_tag,
  input  logic                      rsp_ready
);

  alu_cmd_t cmd_in;
  alu_cmd_t cmd_q;
  logic     cmd_q_valid;
  logic     cmd_q_ready;

  alu_rsp_t rsp_d;
  logic     rsp_d_valid;
  logic     rsp_d_ready;
  alu_rsp_t rsp_q;

  alu_stage_if dec_if ();
  alu_stage_if exe_if ();

  assign cmd_in = '{op: cmd_op, a: cmd_a, b: cmd_b};

  ////////////////////
  // input chain
  ////////////////////
  // last stage passes the stall, decode ready is already combinational
  skid_pipeline #(
    .T              (alu_cmd_t),
    .DEPTH          (`CMD_PIPE_DEPTH),
    .PASS_LAST_STALL(1'b1)
  ) u_cmd_pipe (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (cmd_valid),
    .in_data  (cmd_in),
    .in_ready (cmd_ready),
    .out_valid(cmd_q_valid),
    .out_data (cmd_q),
    .out_ready(cmd_q_ready)
  );

  alu_decode u_decode (
    .clk     (clk),
    .rstn    (rstn),
    .in_valid(cmd_q_valid),
    .in_cmd  (cmd_q),
    .in_ready(cmd_q_ready),
    .dec     (dec_if.producer)
  );

  alu_execute u_execute (
    .clk (clk),
    .rstn(rstn),
    .dec (dec_if.consumer),
    .exe (exe_if.producer)
  );

  alu_result u_result (
    .clk      (clk),
    .rstn     (rstn),
    .exe      (exe_if.consumer),
    .out_valid(rsp_d_valid),
    .out_rsp  (rsp_d),
    .out_ready(rsp_d_ready)
  );

  ////////////////////
  // output chain
  ////////////////////
  skid_pipeline #(
    .T              (alu_rsp_t),
    .DEPTH          (`RSP_PIPE_DEPTH),
    .PASS_LAST_STALL(1'b0)
  ) u_rsp_pipe (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (rsp_d_valid),
    .in_data  (rsp_d),
    .in_ready (rsp_d_ready),
    .out_valid(rsp_valid),
    .out_data (rsp_q),
    .out_ready(rsp_ready)
  );

  assign rsp_result = rsp_q.result;
  assign rsp_flags  = rsp_q.flags;
  assign rsp_tag    = rsp_q.tag;

endmodule

// File: tb/stream_alu_assert.sv
`include "alu_params.svh"

// handshake checks on the top-level response port
module stream_alu_assert
  import alu_rsp_pkg::*;
(
  input logic                      clk,
  input logic                      rstn,
  input logic                      cmd_ready,
  input logic                      rsp_valid,
  input logic                      rsp_ready,
  input alu_word_t                 rsp_result,
  input alu_flags_t                rsp_flags,
  input logic [`ALU_TAG_WIDTH-1:0] rsp_tag
);

  ////////////////////
  // reset behavior
  ////////////////////
  // covers every reset cycle and the first cycle after release
  a_quiet_in_reset: assert property (@(posedge clk) rstn |=> (!rsp_valid && !cmd_ready))
    else $error("rsp_valid or cmd_ready high after a reset cycle");

  ////////////////////
  // stalled response
  ////////////////////
  a_rsp_hold: assert property (@(posedge clk) disable iff (rstn)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_result) && $stable(rsp_flags)
                                  && $stable(rsp_tag)))
    else $error("stalled response dropped or changed before rsp_ready");

endmodule

bind stream_alu_top stream_alu_assert u_assert (
  .clk       (clk),
  .rstn      (rstn),
  .cmd_ready (cmd_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp_result(rsp_result),
  .rsp_flags (rsp_flags),
  .rsp_tag   (rsp_tag)
);

// File: tb/stream_alu_tb.sv
`include "alu_params.svh"

module stream_alu_tb
  import alu_op_pkg::*, alu_rsp_pkg::*;
();

  logic                      clk;
  logic                      rstn;
  logic                      cmd_valid;
  alu_opcode_t               cmd_op;
  alu_word_t                 cmd_a;
  alu_word_t                 cmd_b;
  logic                      cmd_ready;
  logic                      rsp_valid;
  alu_word_t                 rsp_result;
  alu_flags_t                rsp_flags;
  logic [`ALU_TAG_WIDTH-1:0] rsp_tag;
  logic                      rsp_ready;

  // commands and expected responses from the data file
  logic [3:0] op_list [$];
  alu_word_t  a_list [$];
  alu_word_t  b_list [$];
  alu_rsp_t   exp_list [$];

  // expected responses of accepted commands, in order
  alu_rsp_t   exp_q [$];

  int          n_cmds;
  int          rsp_count;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] lfsr_state;

  stream_alu_top u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_result(rsp_result),
    .rsp_flags (rsp_flags),
    .rsp_tag   (rsp_tag),
    .rsp_ready (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////
  // galois form, taps 32 30 26 25
  function automatic logic next_random_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_result(input alu_word_t got, input alu_word_t exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: response %0d result %h, expected %h", $time, idx, got, exp));
    end
  endtask

  task automatic check_flags(input alu_flags_t got, input alu_flags_t exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: response %0d flags %b, expected %b", $time, idx, got, exp));
    end
  endtask

  task automatic check_tag(input logic [`ALU_TAG_WIDTH-1:0] got,
                           input logic [`ALU_TAG_WIDTH-1:0] exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: response %0d tag %0d, expected %0d", $time, idx, got, exp));
    end
  endtask

  ////////////////////
  // load, reset, drive
  ////////////////////
  initial begin : drive
    int          fd;
    int          n_read;
    string       line;
    logic [31:0] f_op, f_a, f_b, f_res, f_flags;
    alu_rsp_t    entry;
    int          sent;
    logic        accepted;
    logic        r0, r1, g0, g1;

    rstn        = 1'b1;
    cmd_valid   = 1'b0;
    cmd_op      = OP_ADD;
    cmd_a       = '0;
    cmd_b       = '0;
    rsp_ready   = 1'b0;
    sent        = 0;
    n_cmds      = 0;
    rsp_count   = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    lfsr_state  = 32'h389dc434;

    fd = $fopen("tb/alu_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file tb/alu_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        n_read = $fgets(line, fd);
        // skip comment and blank lines
        if (n_read > 0 && line.len() > 0 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_flags) == 5) begin
            op_list.push_back(f_op[3:0]);
            a_list.push_back(f_a[`ALU_WIDTH-1:0]);
            b_list.push_back(f_b[`ALU_WIDTH-1:0]);
            entry.result = f_res[`ALU_WIDTH-1:0];
            entry.flags  = f_flags[4:0];
            entry.tag    = n_cmds[`ALU_TAG_WIDTH-1:0];
            exp_list.push_back(entry);
            n_cmds++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_cmds == 0) begin
      abort_run("the stimulus file holds no commands");
    end
    cycle_limit = n_cmds * 4 + 50;

    repeat (2) @(posedge clk);
    #1 rstn = 1'b0;

    forever begin
      @(posedge clk);
      accepted = cmd_valid && cmd_ready;
      #1;
      if (accepted) begin
        exp_q.push_back(exp_list[sent]);
        sent++;
      end
      // back-pressure about one cycle in four
      r0 = next_random_bit();
      r1 = next_random_bit();
      rsp_ready = r0 | r1;
      if (!cmd_valid || accepted) begin
        g0 = next_random_bit();
        g1 = next_random_bit();
        if (sent < n_cmds && (g0 | g1)) begin
          cmd_valid = 1'b1;
          cmd_op    = alu_opcode_t'(op_list[sent]);
          cmd_a     = a_list[sent];
          cmd_b     = b_list[sent];
        end else begin
          cmd_valid = 1'b0;
        end
      end
    end
  end

  ////////////////////
  // response check
  ////////////////////
  always @(posedge clk) begin
    if (!rstn && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("a response arrived with no command outstanding");
      end else begin
        check_result(rsp_result, exp_q[0].result, rsp_count);
        check_flags(rsp_flags, exp_q[0].flags, rsp_count);
        check_tag(rsp_tag, exp_q[0].tag, rsp_count);
        void'(exp_q.pop_front());
        rsp_count++;
        if (rsp_count == n_cmds) begin
          $display("STATUS: PASS");
          $finish;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles with %0d of %0d responses received",
                          cycle_cnt, rsp_count, n_cmds));
    end
  end

endmodule

// File: tb/alu_stimulus.txt
# columns in hex: opcode a b expected_result expected_flags
# flags are {zero, negative, carry, overflow, illegal}
0 0001 0002 0003 00
0 ffff 0001 0000 14
0 7fff 0001 8000 0a
0 8000 8000 0000 16
0 1234 4321 5555 00
1 0005 0003 0002 04
1 0003 0005 fffe 08
1 8000 0001 7fff 06
1 7fff ffff 8000 0a
1 1234 1234 0000 14
2 f0f0 ff00 f000 08
2 0f0f f0f0 0000 10
3 1200 0034 1234 00
3 8000 0001 8001 08
4 aaaa 5555 ffff 08
4 1234 1234 0000 10
9 1234 5678 0000 11
5 0001 000f 8000 08
5 00ff 0004 0ff0 00
5 8001 0011 0002 00
6 8000 000f 0001 00
6 f000 0004 0f00 00
f ffff ffff 0000 11
6 0001 0001 0000 10
0 7fff 7fff fffe 0a
7 0000 0000 0000 11
1 0000 0001 ffff 08

// File: list.f
+incdir+hdl
hdl/alu_rsp_pkg.sv
hdl/alu_op_pkg.sv
hdl/alu_stage_if.sv
hdl/skid_pipeline.sv
hdl/alu_decode.sv
hdl/alu_execute.sv
hdl/alu_result.sv
hdl/stream_alu_top.sv
tb/stream_alu_assert.sv
tb/stream_alu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module stream_alu_tb -f list.f -o sim_stream_alu

# the simulator exits non-zero on a failure, so the log decides the outcome
./obj_dir/sim_stream_alu > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
